// ==== design/nanorv32_pkg.sv ====
// Shared types and constants of the instruction supply unit
// ROM regions and the reset vector are fixed here and not per instance
package nanorv32_pkg;

   // Data and instruction width
   localparam int unsigned xlen        = 32;
   localparam int unsigned urom_addr_w = 5;

   // Micro ROM regions, first and last word of each
   localparam logic [urom_addr_w-1:0] urom_reset_first = 5'd0;
   localparam logic [urom_addr_w-1:0] urom_reset_last  = 5'd1;
   localparam logic [urom_addr_w-1:0] urom_entry_first = 5'd2;
   localparam logic [urom_addr_w-1:0] urom_entry_last  = 5'd18;
   localparam logic [urom_addr_w-1:0] urom_exit_first  = 5'd19;
   localparam logic [urom_addr_w-1:0] urom_exit_last   = 5'd31;

   // First memory fetch after the reset sequence
   localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

   // RV32I major opcodes used by the predecoder
   localparam logic [6:0] op_load  = 7'b0000011;
   localparam logic [6:0] op_imm   = 7'b0010011;
   localparam logic [6:0] op_jalr  = 7'b1100111;
   localparam logic [6:0] op_store = 7'b0100011;
   localparam logic [6:0] op_lui   = 7'b0110111;
   localparam logic [6:0] op_auipc = 7'b0010111;

   // One instruction word seen through the RV32I formats
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm_11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm_11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic [19:0] imm_31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
   } rv32_instr_u;

   // Where an instruction came from
   typedef enum logic [1:0] {
      src_mem,
      src_reset,
      src_entry,
      src_exit
   } instr_src_e;

   // Word travelling fetch -> sequencer -> predecoder
   typedef struct packed {
      rv32_instr_u     instr;
      logic [xlen-1:0] pc;
      instr_src_e      src;
   } fetch_word_s;

   // Unit output, fields split out of the word
   typedef struct packed {
      logic [6:0]      opcode;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [2:0]      funct3;
      logic [xlen-1:0] imm;
      logic [xlen-1:0] pc;
      instr_src_e      src;
      logic [xlen-1:0] raw;
   } decoded_s;

endpackage

// ==== design/nanorv32_urom.sv ====
// Asynchronous micro ROM, 32 words, no clock
// Table body is generated from the micro-ROM assembly source
`timescale 1ns/1ns

module nanorv32_urom import nanorv32_pkg::*; (
   input  logic [urom_addr_w-1:0] addr,
   output logic [xlen-1:0]        dout
);

   // Plain case table, synthesis picks the implementation
   always_comb begin
      case (addr)
         // Begin of generated micro ROM table
         // Reset region
         5'd0:  dout = 32'h00100093;
         5'd1:  dout = 32'h00000013;
         // Interrupt entry region, saves registers on the stack
         5'd2:  dout = 32'hfe112c23;
         5'd3:  dout = 32'hfe212a23;
         5'd4:  dout = 32'hfe512823;
         5'd5:  dout = 32'hfe612623;
         5'd6:  dout = 32'hfe712423;
         5'd7:  dout = 32'hfea12223;
         5'd8:  dout = 32'hfeb12023;
         5'd9:  dout = 32'hfcc12e23;
         5'd10: dout = 32'hfcd12c23;
         5'd11: dout = 32'hfce12a23;
         5'd12: dout = 32'hfcf12823;
         5'd13: dout = 32'hfff00093;
         5'd14: dout = 32'h00000297;
         5'd15: dout = 32'hfc512623;
         5'd16: dout = 32'hfcc10113;
         5'd17: dout = 32'h08002503;
         5'd18: dout = 32'h00050067;
         // Interrupt exit region, restores registers
         5'd19: dout = 32'h02c12083;
         5'd20: dout = 32'h02412283;
         5'd21: dout = 32'h02012303;
         5'd22: dout = 32'h01c12383;
         5'd23: dout = 32'h01812503;
         5'd24: dout = 32'h01412583;
         5'd25: dout = 32'h01012603;
         5'd26: dout = 32'h00c12683;
         5'd27: dout = 32'h00812703;
         5'd28: dout = 32'h00412783;
         5'd29: dout = 32'h00012003;
         5'd30: dout = 32'h02812103;
         5'd31: dout = 32'h00000067;
         // End of generated micro ROM table
         default: begin
            // Unused addresses read as zero
            dout = '0;
         end
      endcase
   end

endmodule

// ==== design/nanorv32_fetch.sv ====
// Fetch unit, one outstanding program memory read and a one-word buffer
// Responses are always accepted; a redirect drops buffered and in-flight words
`timescale 1ns/1ns

module nanorv32_fetch import nanorv32_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            hold,
   input  logic            redirect_valid,
   input  logic [xlen-1:0] redirect_pc,
   input  logic            mem_req_ready,
   input  logic            mem_rsp_valid,
   input  logic [xlen-1:0] mem_rsp_data,
   input  logic            fw_ready,
   output logic            mem_req_valid,
   output logic [xlen-1:0] mem_req_addr,
   output logic            fw_valid,
   output fetch_word_s     fw,
   output logic            idle
);

   logic [xlen-1:0] pc;
   logic            req_valid;
   logic [xlen-1:0] req_addr;
   logic            busy;
   logic            discard;
   logic            word_valid;
   fetch_word_s     word_q;
   logic            req_fire;
   logic            rsp_take;
   logic            issue_ok;

   assign req_fire = req_valid & mem_req_ready;
   // One read at most, so any response belongs to the outstanding one
   assign rsp_take = mem_rsp_valid & busy;

   // New request only with nothing in flight and room for its word
   assign issue_ok = !req_valid && !busy && !hold && !redirect_valid &&
                     (!word_valid || fw_ready);

   // Request and word tracking
   always_ff @(posedge clk) begin
      if (rst) begin
         pc         <= reset_vector;
         req_valid  <= 1'b0;
         busy       <= 1'b0;
         discard    <= 1'b0;
         word_valid <= 1'b0;
      end else begin
         // Valid stays up with a stable address until accepted
         if (req_fire) begin
            req_valid <= 1'b0;
         end else if (issue_ok) begin
            req_valid <= 1'b1;
         end

         if (req_fire) begin
            busy <= 1'b1;
         end else if (rsp_take) begin
            busy <= 1'b0;
         end

         // Counter steps on accept, redirect overrides
         if (req_fire && !discard) begin
            pc <= pc + 32'd4;
         end
         if (redirect_valid) begin
            pc <= redirect_pc;
         end

         // Read issued or in flight before a redirect is stale
         if (redirect_valid && ((busy && !mem_rsp_valid) || req_valid)) begin
            discard <= 1'b1;
         end else if (rsp_take) begin
            discard <= 1'b0;
         end

         if (redirect_valid) begin
            word_valid <= 1'b0;
         end else if (rsp_take && !discard) begin
            word_valid <= 1'b1;
         end else if (fw_ready) begin
            word_valid <= 1'b0;
         end
      end
   end

   // Payload, no reset
   always_ff @(posedge clk) begin
      if (issue_ok) begin
         req_addr <= pc;
      end
      if (rsp_take && !discard) begin
         word_q.instr <= mem_rsp_data;
         word_q.pc    <= req_addr;
         word_q.src   <= src_mem;
      end
   end

   assign mem_req_valid = req_valid;
   assign mem_req_addr  = req_addr;
   assign fw_valid      = word_valid;
   assign fw            = word_q;
   assign idle          = !req_valid && !busy && !word_valid;

endmodule

// ==== design/nanorv32_useq.sv ====
// Micro sequencer, injects ROM sequences for reset, interrupt entry and exit
// Interrupt requests wait in pending flags until fetch has gone idle
`timescale 1ns/1ns

module nanorv32_useq import nanorv32_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        irq_req,
   input  logic        irq_exit,
   input  logic        idle,
   input  logic        fw_valid,
   input  fetch_word_s fw,
   input  logic        sq_ready,
   output logic        fw_ready,
   output logic        hold,
   output logic        sq_valid,
   output fetch_word_s sq
);

   typedef enum logic [1:0] {
      reset_seq,
      mem,
      entry_seq,
      exit_seq
   } useq_state_e;

   useq_state_e            state;
   logic [urom_addr_w-1:0] rom_addr;
   logic [xlen-1:0]        rom_word;
   logic                   entry_pend;
   logic                   exit_pend;
   logic                   rom_last;
   logic                   rom_fire;
   logic                   take_entry;
   logic                   take_exit;

   nanorv32_urom u_urom (
      .addr (rom_addr),
      .dout (rom_word)
   );

   // Output mux and end-of-region detect
   always_comb begin
      sq_valid = 1'b1;
      fw_ready = 1'b0;
      sq.instr = rom_word;
      sq.pc    = '0;
      sq.src   = src_reset;
      rom_last = 1'b0;
      case (state)
         reset_seq: begin
            rom_last = (rom_addr == urom_reset_last);
         end
         entry_seq: begin
            sq.src   = src_entry;
            rom_last = (rom_addr == urom_entry_last);
         end
         exit_seq: begin
            sq.src   = src_exit;
            rom_last = (rom_addr == urom_exit_last);
         end
         default: begin
            // Memory mode, straight pass-through
            sq_valid = fw_valid;
            sq       = fw;
            fw_ready = sq_ready;
         end
      endcase
   end

   assign rom_fire   = (state != mem) && sq_ready;
   // Entry wins when both are waiting
   assign take_entry = (state == mem) && idle && entry_pend;
   assign take_exit  = (state == mem) && idle && exit_pend && !entry_pend;

   // Pending flags raise hold one cycle after the pulse
   assign hold = (state != mem) || entry_pend || exit_pend;

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= reset_seq;
         rom_addr   <= urom_reset_first;
         entry_pend <= 1'b0;
         exit_pend  <= 1'b0;
      end else begin
         entry_pend <= (entry_pend && !take_entry) || irq_req;
         exit_pend  <= (exit_pend && !take_exit) || irq_exit;

         if (take_entry) begin
            state    <= entry_seq;
            rom_addr <= urom_entry_first;
         end else if (take_exit) begin
            state    <= exit_seq;
            rom_addr <= urom_exit_first;
         end else if (rom_fire) begin
            if (rom_last) begin
               state <= mem;
            end else begin
               rom_addr <= rom_addr + 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/nanorv32_predecode.sv ====
// Predecoder with a one-stage output register
// Immediate follows the opcode format; unknown formats give imm zero
`timescale 1ns/1ns

module nanorv32_predecode import nanorv32_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        sq_valid,
   input  fetch_word_s sq,
   input  logic        out_ready,
   output logic        sq_ready,
   output logic        out_valid,
   output decoded_s    out_instr
);

   rv32_instr_u     w;
   logic [6:0]      opcode;
   logic [xlen-1:0] imm;
   decoded_s        dec;
   logic            load;

   assign w      = sq.instr;
   assign opcode = w.r.opcode;

   // Immediate by format view
   always_comb begin
      case (opcode)
         op_load, op_imm, op_jalr: begin
            // I format, 12 bits sign-extended
            imm = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
         end
         op_store: begin
            imm = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
         end
         op_lui, op_auipc: begin
            // U format, upper 20 bits
            imm = {w.u.imm_31_12, 12'h000};
         end
         default: begin
            imm = '0;
         end
      endcase
   end

   // Register fields sit at fixed positions in every format
   always_comb begin
      dec.opcode = opcode;
      dec.rd     = w.r.rd;
      dec.rs1    = w.r.rs1;
      dec.rs2    = w.r.rs2;
      dec.funct3 = w.r.funct3;
      dec.imm    = imm;
      dec.pc     = sq.pc;
      dec.src    = sq.src;
      dec.raw    = w;
   end

   // Accept while empty or being emptied this cycle
   assign sq_ready = !out_valid || out_ready;
   assign load     = sq_valid && sq_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (sq_ready) begin
         out_valid <= sq_valid;
      end
   end

   // Held under back-pressure since load needs sq_ready
   always_ff @(posedge clk) begin
      if (load) begin
         out_instr <= dec;
      end
   end

endmodule

// ==== design/nanorv32_ifu.sv ====
// Instruction supply unit, fetch -> micro sequencer -> predecoder
// Program memory must allow a single outstanding read
`timescale 1ns/1ns

module nanorv32_ifu import nanorv32_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   output logic            mem_req_valid,
   output logic [xlen-1:0] mem_req_addr,
   input  logic            mem_req_ready,
   input  logic            mem_rsp_valid,
   input  logic [xlen-1:0] mem_rsp_data,
   input  logic            irq_req,
   input  logic            irq_exit,
   input  logic            redirect_valid,
   input  logic [xlen-1:0] redirect_pc,
   output logic            out_valid,
   input  logic            out_ready,
   output decoded_s        out_instr
);

   // Fetch to sequencer
   logic        fw_valid;
   logic        fw_ready;
   fetch_word_s fw;
   logic        idle;
   logic        hold;
   // Sequencer to predecoder
   logic        sq_valid;
   logic        sq_ready;
   fetch_word_s sq;

   nanorv32_fetch u_fetch (
      .clk            (clk),
      .rst            (rst),
      .hold           (hold),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .mem_req_ready  (mem_req_ready),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_data   (mem_rsp_data),
      .fw_ready       (fw_ready),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .fw_valid       (fw_valid),
      .fw             (fw),
      .idle           (idle)
   );

   nanorv32_useq u_useq (
      .clk      (clk),
      .rst      (rst),
      .irq_req  (irq_req),
      .irq_exit (irq_exit),
      .idle     (idle),
      .fw_valid (fw_valid),
      .fw       (fw),
      .sq_ready (sq_ready),
      .fw_ready (fw_ready),
      .hold     (hold),
      .sq_valid (sq_valid),
      .sq       (sq)
   );

   nanorv32_predecode u_predecode (
      .clk       (clk),
      .rst       (rst),
      .sq_valid  (sq_valid),
      .sq        (sq),
      .out_ready (out_ready),
      .sq_ready  (sq_ready),
      .out_valid (out_valid),
      .out_instr (out_instr)
   );

endmodule

// ==== verification/nanorv32_ifu_properties.sv ====
// Concurrent checks on the unit output, bound into nanorv32_ifu
// Expected words come from the testbench scoreboard through the bind ports
`timescale 1ns/1ns

module nanorv32_ifu_properties import nanorv32_pkg::*; (
   input logic     clk,
   input logic     rst,
   input logic     mem_req_valid,
   input logic     out_valid,
   input logic     out_ready,
   input decoded_s out_instr,
   input logic     rom_active,
   input logic     rom_armed,
   input logic     redir_pend,
   input logic     stale_ok,
   input decoded_s exp_rom,
   input decoded_s exp_mem,
   input decoded_s exp_new
);

   // Nothing leaves the unit in the cycle after reset
   a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid && !mem_req_valid)
      else begin
         nanorv32_ifu_tb.err_count++;
         $error("Output or memory request valid right after reset");
      end

   // Inside a ROM sequence only the next ROM word may leave
   a_rom_word: assert property (@(posedge clk) disable iff (rst)
      out_valid && out_ready && rom_active |-> out_instr == exp_rom)
      else begin
         nanorv32_ifu_tb.err_count++;
         $error("Mismatch out_instr exp %h got %h", $sampled(exp_rom), $sampled(out_instr));
      end

   // Otherwise next sequential word, first word at a redirect target, or a ROM start
   // After a redirect only the word already in the output register may be an old one
   a_mem_word: assert property (@(posedge clk) disable iff (rst)
      out_valid && out_ready && !rom_active |->
         (out_instr == exp_mem && (!redir_pend || stale_ok)) ||
         (redir_pend && out_instr == exp_new) ||
         (rom_armed && out_instr == exp_rom))
      else begin
         nanorv32_ifu_tb.err_count++;
         $error("Mismatch out_instr exp %h got %h", $sampled(exp_mem), $sampled(out_instr));
      end

   // Stalled output holds
   a_stall_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_instr))
      else begin
         nanorv32_ifu_tb.err_count++;
         $error("Output changed or dropped while out_ready was low");
      end

endmodule

// ==== verification/nanorv32_ifu_tb.sv ====
// Testbench for the instruction supply unit, memory model with 1 to 3 cycle latency
// Checking lives in the bound properties; this module keeps the scoreboard state
`timescale 1ns/1ns

module nanorv32_ifu_tb;
   import nanorv32_pkg::*;

   // Six tests of about 60 transfers, up to 8 cycles each at the longest latency
   localparam int cycle_limit = 6 * 60 * 8;
   localparam int seed        = 60164;

   logic        clk = 1'b0;
   logic        rst;
   logic        mem_req_valid;
   logic [31:0] mem_req_addr;
   logic        mem_req_ready;
   logic        mem_rsp_valid;
   logic [31:0] mem_rsp_data;
   logic        irq_req;
   logic        irq_exit;
   logic        redirect_valid;
   logic [31:0] redirect_pc;
   logic        out_valid;
   logic        out_ready;
   decoded_s    out_instr;

   // Scoreboard state
   logic        rom_active;
   logic        rom_armed;
   logic [4:0]  rom_next;
   logic [4:0]  rom_end;
   instr_src_e  rom_src;
   logic [31:0] exp_pc;
   logic        redir_pend;
   logic        stale_ok;
   logic [31:0] redir_pc;
   decoded_s    exp_mem;
   decoded_s    exp_new;
   decoded_s    exp_rom;
   int          xfer_count = 0;
   int          err_count  = 0;
   int          cycles     = 0;
   int          stall_pct  = 25;
   int          rsp_wait;
   logic [31:0] rsp_addr;
   int          xfer_start;
   int          err_start;

   // Reference micro ROM, reset 0-1, entry 2-18, exit 19-31
   logic [31:0] rom_copy [32] = '{
      32'h00100093, 32'h00000013, 32'hfe112c23, 32'hfe212a23,
      32'hfe512823, 32'hfe612623, 32'hfe712423, 32'hfea12223,
      32'hfeb12023, 32'hfcc12e23, 32'hfcd12c23, 32'hfce12a23,
      32'hfcf12823, 32'hfff00093, 32'h00000297, 32'hfc512623,
      32'hfcc10113, 32'h08002503, 32'h00050067, 32'h02c12083,
      32'h02412283, 32'h02012303, 32'h01c12383, 32'h01812503,
      32'h01412583, 32'h01012603, 32'h00c12683, 32'h00812703,
      32'h00412783, 32'h00012003, 32'h02812103, 32'h00000067
   };

   nanorv32_ifu u_dut (
      .clk            (clk),
      .rst            (rst),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .mem_req_ready  (mem_req_ready),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_data   (mem_rsp_data),
      .irq_req        (irq_req),
      .irq_exit       (irq_exit),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_instr      (out_instr)
   );

   bind nanorv32_ifu nanorv32_ifu_properties u_props (
      .clk           (clk),
      .rst           (rst),
      .mem_req_valid (mem_req_valid),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_instr     (out_instr),
      .rom_active    (nanorv32_ifu_tb.rom_active),
      .rom_armed     (nanorv32_ifu_tb.rom_armed),
      .redir_pend    (nanorv32_ifu_tb.redir_pend),
      .stale_ok      (nanorv32_ifu_tb.stale_ok),
      .exp_rom       (nanorv32_ifu_tb.exp_rom),
      .exp_mem       (nanorv32_ifu_tb.exp_mem),
      .exp_new       (nanorv32_ifu_tb.exp_new)
   );

   always #2 clk = ~clk;

   // Program memory content, format picked by address bits 3:2
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [11:0] imm12;
      logic [4:0]  ra;
      logic [4:0]  rb;
      imm12 = {addr[4], addr[14:4]};
      ra    = addr[8:4];
      rb    = addr[13:9];
      case (addr[3:2])
         // Load or addi, bit 5 chooses
         2'd0: return {imm12, ra, 3'b010, rb, addr[5] ? 7'b0000011 : 7'b0010011};
         2'd1: return {imm12[11:5], rb, ra, 3'b010, imm12[4:0], 7'b0100011};
         2'd2: return {addr[23:4], rb, 7'b0110111};
         default: return {7'b0000000, rb, ra, 3'b000, ra ^ rb, 7'b0110011};
      endcase
   endfunction

   // RV32I field split, immediate by format
   function automatic decoded_s predict(input logic [31:0] word, input logic [31:0] pc,
                                        input instr_src_e src);
      decoded_s d;
      d.opcode = word[6:0];
      d.rd     = word[11:7];
      d.funct3 = word[14:12];
      d.rs1    = word[19:15];
      d.rs2    = word[24:20];
      case (word[6:0])
         7'b0000011, 7'b0010011, 7'b1100111: d.imm = {{20{word[31]}}, word[31:20]};
         7'b0100011: d.imm = {{20{word[31]}}, word[31:25], word[11:7]};
         7'b0110111, 7'b0010111: d.imm = {word[31:12], 12'h000};
         default: d.imm = 32'h0;
      endcase
      d.pc  = pc;
      d.src = src;
      d.raw = word;
      return d;
   endfunction

   always_comb begin
      exp_mem = predict(mem_word(exp_pc), exp_pc, src_mem);
      exp_new = predict(mem_word(redir_pc), redir_pc, src_mem);
      exp_rom = predict(rom_copy[rom_next], 32'h0, rom_src);
   end

   // Scoreboard, advanced on each output transfer
   always @(posedge clk) begin
      if (rst) begin
         rom_active <= 1'b1;
         rom_armed  <= 1'b0;
         rom_next   <= 5'd0;
         rom_end    <= 5'd1;
         rom_src    <= src_reset;
         exp_pc     <= reset_vector;
         redir_pend <= 1'b0;
         stale_ok   <= 1'b0;
         xfer_count <= 0;
      end else begin
         if (irq_req || irq_exit) begin
            rom_armed <= 1'b1;
            rom_next  <= irq_req ? 5'd2 : 5'd19;
            rom_end   <= irq_req ? 5'd18 : 5'd31;
            rom_src   <= irq_req ? src_entry : src_exit;
         end
         if (redirect_valid) begin
            redir_pend <= 1'b1;
            stale_ok   <= 1'b1;
            redir_pc   <= redirect_pc;
         end
         if (out_valid && out_ready) begin
            xfer_count <= xfer_count + 1;
            // Only the word held in the output register at the redirect may still be old
            stale_ok   <= redirect_valid;
            if (rom_active || (rom_armed && out_instr == exp_rom)) begin
               rom_armed  <= 1'b0;
               rom_active <= (rom_next != rom_end);
               rom_next   <= rom_next + 5'd1;
            end else if (redir_pend && out_instr == exp_new) begin
               redir_pend <= 1'b0;
               exp_pc     <= redir_pc + 32'd4;
            end else begin
               exp_pc <= exp_pc + 32'd4;
            end
         end
      end
   end

   // Memory responses and random out_ready, all on the falling edge
   initial begin
      void'($urandom(seed));
      mem_rsp_valid = 1'b0;
      mem_rsp_data  = 32'h0;
      out_ready     = 1'b1;
      rsp_wait      = 0;
      forever begin
         @(negedge clk);
         mem_rsp_valid = 1'b0;
         if (rsp_wait > 0) begin
            rsp_wait = rsp_wait - 1;
            if (rsp_wait == 0) begin
               mem_rsp_valid = 1'b1;
               mem_rsp_data  = mem_word(rsp_addr);
            end
         end
         // Accepted at the coming rising edge
         if (mem_req_valid && mem_req_ready) begin
            rsp_wait = 1 + ($urandom % 3);
            rsp_addr = mem_req_addr;
         end
         out_ready = ($urandom % 100) >= stall_pct;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Run stopped at the cycle limit of %0d with a test still waiting", cycle_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic start_test();
      xfer_start = xfer_count;
      err_start  = err_count;
   endtask

   task automatic report_test(input string name);
      $display("%-16s done  transfers %0d  errors %0d", name, xfer_count - xfer_start,
               err_count - err_start);
   endtask

   task automatic run_transfers(input int n);
      int target;
      target = xfer_count + n;
      while (xfer_count < target) @(posedge clk);
   endtask

   task automatic finish_rom_sequence();
      while (rom_armed || rom_active) @(posedge clk);
   endtask

   task automatic settle_redirect();
      while (redir_pend) @(posedge clk);
   endtask

   // Read accepted with at least one more cycle to go
   task automatic catch_outstanding_read();
      do @(posedge clk); while (rsp_wait < 2);
   endtask

   task automatic pulse_irq(input logic entry);
      @(negedge clk);
      irq_req  = entry;
      irq_exit = !entry;
      @(negedge clk);
      irq_req  = 1'b0;
      irq_exit = 1'b0;
   endtask

   task automatic pulse_redirect(input logic [31:0] target);
      @(negedge clk);
      redirect_valid = 1'b1;
      redirect_pc    = target;
      @(negedge clk);
      redirect_valid = 1'b0;
   endtask

   task automatic set_stall(input int pct);
      @(posedge clk);
      stall_pct = pct;
   endtask

   initial begin
      rst            = 1'b1;
      mem_req_ready  = 1'b1;
      irq_req        = 1'b0;
      irq_exit       = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc    = 32'h0;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      start_test();
      run_transfers(10);
      report_test("reset_startup");

      start_test();
      run_transfers(40);
      report_test("sequential");

      start_test();
      pulse_irq(1'b1);
      finish_rom_sequence();
      run_transfers(10);
      report_test("irq_entry");

      start_test();
      pulse_irq(1'b0);
      finish_rom_sequence();
      run_transfers(10);
      report_test("irq_exit");

      // Second redirect lands while a read is outstanding
      start_test();
      pulse_redirect(32'h0000_0400);
      settle_redirect();
      run_transfers(8);
      catch_outstanding_read();
      pulse_redirect(32'h0000_1200);
      settle_redirect();
      run_transfers(8);
      report_test("redirect");

      start_test();
      set_stall(60);
      run_transfers(60);
      report_test("back_pressure");

      $display("tests 6  transfers %0d  errors %0d  cycles %0d", xfer_count, err_count, cycles);
      if (err_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
design/nanorv32_pkg.sv
design/nanorv32_urom.sv
design/nanorv32_fetch.sv
design/nanorv32_useq.sv
design/nanorv32_predecode.sv
design/nanorv32_ifu.sv
verification/nanorv32_ifu_properties.sv
verification/nanorv32_ifu_tb.sv

// ==== Bender.yml ====
package:
  name: nanorv32_ifu

sources:
  - design/nanorv32_pkg.sv
  - design/nanorv32_urom.sv
  - design/nanorv32_fetch.sv
  - design/nanorv32_useq.sv
  - design/nanorv32_predecode.sv
  - design/nanorv32_ifu.sv
  - target: test
    files:
      - verification/nanorv32_ifu_properties.sv
      - verification/nanorv32_ifu_tb.sv
